// ==== hw/merging_fifo_cfg.svh ====
//--------------------------------------
// Merging FIFO configuration
// Depth, word width, almost-full level and
// repeat-count width of the merging FIFO
//--------------------------------------
`ifndef MERGING_FIFO_CFG_SVH
`define MERGING_FIFO_CFG_SVH
`default_nettype none

`define MF_DEPTH        8
`define MF_DATA_WIDTH   8
`define MF_THRESHOLD    6
// Two bits let one entry stand for up to three equal pushes
`define MF_MATCH_WIDTH  2

`default_nettype wire
`endif

// ==== hw/merging_fifo_pkg.sv ====
//--------------------------------------
// Merging FIFO types
// Data, pointer, count, status and storage
// control types shared by all blocks
//--------------------------------------
`include "merging_fifo_cfg.svh"
`default_nettype none

package merging_fifo_pkg;
  typedef logic [`MF_DATA_WIDTH-1:0]      data_t;
  typedef logic [$clog2(`MF_DEPTH-1)-1:0] ram_ptr_t;
  typedef logic [$clog2(`MF_DEPTH)-1:0]   slot_ptr_t;
  typedef logic [$clog2(`MF_DEPTH+1)-1:0] count_t;
  typedef logic [`MF_MATCH_WIDTH-1:0]     match_t;

  typedef struct packed {
    logic empty;
    logic almost_full;
    logic full;
  } fifo_status_t;

  typedef struct packed {
    ram_ptr_t write_ptr;
    logic     write_to_head;
    logic     write_to_ram;
    ram_ptr_t read_ptr;
    logic     read_from_ram;
  } storage_ctrl_t;
endpackage

`default_nettype wire

// ==== hw/merging_fifo_controller.sv ====
//--------------------------------------
// Merging FIFO controller
// Entry count, registered flags, write steering,
// array pointers and per-entry repeat counts
//--------------------------------------
`include "merging_fifo_cfg.svh"
`default_nettype none

module merging_fifo_controller (
  input  var logic                          i_clk,
  input  var logic                          i_rst_n,
  input  var logic                          i_clear,
  input  var logic                          i_push,
  input  var merging_fifo_pkg::data_t       i_data,
  input  var logic                          i_pop,
  output var merging_fifo_pkg::fifo_status_t  o_status,
  output var merging_fifo_pkg::count_t        o_word_count,
  output var merging_fifo_pkg::storage_ctrl_t o_ctrl
);
  import merging_fifo_pkg::*;

  fifo_status_t         status_q;
  fifo_status_t         status_next;
  count_t               word_count;
  count_t               word_count_next;
  logic                 pop_any;
  logic                 pop;
  logic                 push;
  logic                 merge;
  logic                 match_data;
  logic                 last_pop;
  logic                 count_eq_1;
  logic                 count_eq_2;
  logic                 count_ge_2;
  logic                 write_to_head;
  logic                 write_to_ram;
  logic                 read_from_ram;
  logic                 ram_empty_next;
  ram_ptr_t             ram_wr_ptr;
  ram_ptr_t             ram_rd_ptr;
  slot_ptr_t            slot_wr_ptr;
  slot_ptr_t            slot_rd_ptr;
  slot_ptr_t            slot_newest;
  data_t                last_data;
  match_t [`MF_DEPTH-1:0] repeat_count;

  function automatic ram_ptr_t next_ram_ptr(ram_ptr_t ptr);
    if (ptr == ram_ptr_t'(`MF_DEPTH - 2)) begin
      return '0;
    end
    return ptr + ram_ptr_t'(1);
  endfunction

  function automatic slot_ptr_t next_slot_ptr(slot_ptr_t ptr);
    if (ptr == slot_ptr_t'(`MF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + slot_ptr_t'(1);
  endfunction

  // A pop always lowers the oldest count, but the entry only leaves
  // when that count is down to one
  always_comb begin
    pop_any  = i_pop && !status_q.empty;
    last_pop = repeat_count[slot_rd_ptr] == match_t'(1);
    pop      = pop_any && last_pop;
  end

  // The newest entry sits one slot behind the write slot
  always_comb begin
    if (slot_wr_ptr == '0) begin
      slot_newest = slot_ptr_t'(`MF_DEPTH - 1);
    end else begin
      slot_newest = slot_wr_ptr - slot_ptr_t'(1);
    end
  end

  // No merge into an entry that leaves in this same cycle
  always_comb begin
    match_data = !status_q.empty && (i_data == last_data) &&
                 (repeat_count[slot_newest] != '1) && !(pop && count_eq_1);
    merge      = i_push && match_data;
    push       = i_push && !status_q.full && !match_data;
  end

  always_comb begin
    case ({push, pop})
      2'b10:   word_count_next = word_count + count_t'(1);
      2'b01:   word_count_next = word_count - count_t'(1);
      default: word_count_next = word_count;
    endcase
  end

  always_comb begin
    count_eq_1 = word_count == count_t'(1);
    count_eq_2 = word_count == count_t'(2);
    count_ge_2 = word_count >= count_t'(2);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      word_count <= '0;
    end else if (i_clear) begin
      word_count <= '0;
    end else if (push || pop) begin
      word_count <= word_count_next;
    end
  end

  always_comb begin
    status_next.empty       = word_count_next == '0;
    status_next.almost_full = word_count_next >= count_t'(`MF_THRESHOLD);
    status_next.full        = word_count_next >= count_t'(`MF_DEPTH);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      status_q <= '{empty: 1'b1, default: 1'b0};
    end else if (i_clear) begin
      status_q <= '{empty: 1'b1, default: 1'b0};
    end else if (push || pop) begin
      status_q <= status_next;
    end
  end

  // Full is dropped at once when the push folds into the newest entry
  always_comb begin
    o_status.empty       = status_q.empty;
    o_status.almost_full = status_q.almost_full;
    o_status.full        = status_q.full && !match_data;
    o_word_count         = word_count;
  end

  // The head register takes the push when it would otherwise be empty
  always_comb begin
    write_to_head  = push && (status_q.empty || (count_eq_1 && pop));
    write_to_ram   = push && ((count_eq_1 && !pop) || count_ge_2);
    read_from_ram  = pop && count_ge_2;
    ram_empty_next = read_from_ram && !write_to_ram && count_eq_2;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ram_wr_ptr <= '0;
      ram_rd_ptr <= '0;
    end else if (i_clear) begin
      ram_wr_ptr <= '0;
      ram_rd_ptr <= '0;
    end else if (ram_empty_next) begin
      // Array drains, so both pointers meet on the read slot
      ram_wr_ptr <= ram_rd_ptr;
    end else begin
      if (write_to_ram) begin
        ram_wr_ptr <= next_ram_ptr(ram_wr_ptr);
      end
      if (read_from_ram) begin
        ram_rd_ptr <= next_ram_ptr(ram_rd_ptr);
      end
    end
  end

  always_comb begin
    o_ctrl.write_ptr     = ram_wr_ptr;
    o_ctrl.write_to_head = write_to_head;
    o_ctrl.write_to_ram  = write_to_ram;
    o_ctrl.read_ptr      = ram_rd_ptr;
    o_ctrl.read_from_ram = read_from_ram;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slot_wr_ptr <= '0;
      slot_rd_ptr <= '0;
    end else if (i_clear) begin
      slot_wr_ptr <= '0;
      slot_rd_ptr <= '0;
    end else begin
      if (push) begin
        slot_wr_ptr <= next_slot_ptr(slot_wr_ptr);
      end
      if (pop) begin
        slot_rd_ptr <= next_slot_ptr(slot_rd_ptr);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      last_data <= i_data;
    end
  end

  for (genvar i = 0; i < `MF_DEPTH; i++) begin : g_repeat
    logic load;
    logic inc;
    logic dec;

    always_comb begin
      load = push && (slot_wr_ptr == slot_ptr_t'(i));
      inc  = merge && (slot_newest == slot_ptr_t'(i));
      dec  = pop_any && (slot_rd_ptr == slot_ptr_t'(i));
    end

    // A merge and a pop on the same entry cancel out
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        repeat_count[i] <= '0;
      end else if (i_clear) begin
        repeat_count[i] <= '0;
      end else if (load) begin
        repeat_count[i] <= match_t'(1);
      end else if (inc && !dec) begin
        repeat_count[i] <= repeat_count[i] + match_t'(1);
      end else if (dec && !inc) begin
        repeat_count[i] <= repeat_count[i] - match_t'(1);
      end
    end
  end

  a_single_write: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(write_to_head && write_to_ram));

  a_count_range: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) word_count <= count_t'(`MF_DEPTH));

  // The registered empty flag must agree with the live count
  a_no_pop_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) pop_any |-> (word_count != '0));
endmodule

`default_nettype wire

// ==== hw/merging_fifo_storage.sv ====
//--------------------------------------
// Merging FIFO storage
// DEPTH-1 word array, one write port and
// one combinational read port
//--------------------------------------
`include "merging_fifo_cfg.svh"
`default_nettype none

module merging_fifo_storage (
  input  var logic                            i_clk,
  input  var merging_fifo_pkg::storage_ctrl_t i_ctrl,
  input  var merging_fifo_pkg::data_t         i_data,
  output var merging_fifo_pkg::data_t         o_rd_data
);
  import merging_fifo_pkg::*;

  // The head register holds one entry, so the array needs one less
  data_t mem [`MF_DEPTH-1];

  always_ff @(posedge i_clk) begin
    if (i_ctrl.write_to_ram) begin
      mem[i_ctrl.write_ptr] <= i_data;
    end
  end

  always_comb begin
    o_rd_data = mem[i_ctrl.read_ptr];
  end

  // Pointers wrap in the controller at the last word
  a_ptr_range: assert property (
    @(posedge i_clk)
      (i_ctrl.write_ptr <= ram_ptr_t'(`MF_DEPTH - 2)) &&
      (i_ctrl.read_ptr <= ram_ptr_t'(`MF_DEPTH - 2)));
endmodule

`default_nettype wire

// ==== hw/merging_fifo_head.sv ====
//--------------------------------------
// Merging FIFO head register
// Holds the word at the head of the FIFO
//--------------------------------------
`default_nettype none

module merging_fifo_head (
  input  var logic                            i_clk,
  input  var logic                            i_rst_n,
  input  var merging_fifo_pkg::storage_ctrl_t i_ctrl,
  input  var merging_fifo_pkg::data_t         i_data,
  input  var merging_fifo_pkg::data_t         i_rd_data,
  output var merging_fifo_pkg::data_t         o_data
);
  import merging_fifo_pkg::*;

  data_t head_q;

  // Push data goes straight in when the FIFO is nearly empty,
  // otherwise the next word comes up from the array
  always_ff @(posedge i_clk) begin
    if (i_ctrl.write_to_head) begin
      head_q <= i_data;
    end else if (i_ctrl.read_from_ram) begin
      head_q <= i_rd_data;
    end
  end

  always_comb begin
    o_data = head_q;
  end

  // The controller never refills the head from both sources at once
  a_one_source: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      !(i_ctrl.write_to_head && i_ctrl.read_from_ram));
endmodule

`default_nettype wire

// ==== hw/merging_fifo.sv ====
//--------------------------------------
// Merging FIFO top level
// Show-ahead FIFO that folds equal pushes
// into one entry with a repeat count
//--------------------------------------
`default_nettype none

module merging_fifo (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_clear,
  input  var logic                           i_push,
  input  var merging_fifo_pkg::data_t        i_data,
  input  var logic                           i_pop,
  output var merging_fifo_pkg::data_t        o_data,
  output var merging_fifo_pkg::fifo_status_t o_status,
  output var merging_fifo_pkg::count_t       o_word_count
);
  import merging_fifo_pkg::*;

  storage_ctrl_t ctrl;
  data_t         rd_data;

  merging_fifo_controller controller_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_push       (i_push),
    .i_data       (i_data),
    .i_pop        (i_pop),
    .o_status     (o_status),
    .o_word_count (o_word_count),
    .o_ctrl       (ctrl)
  );

  merging_fifo_storage storage_inst (
    .i_clk     (i_clk),
    .i_ctrl    (ctrl),
    .i_data    (i_data),
    .o_rd_data (rd_data)
  );

  merging_fifo_head head_inst (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_ctrl    (ctrl),
    .i_data    (i_data),
    .i_rd_data (rd_data),
    .o_data    (o_data)
  );
endmodule

`default_nettype wire

// ==== verification/merging_fifo_tb.sv ====
//----------------------------------------
// Merging FIFO testbench
// Seeded random traffic checked against a
// run-length queue model of the FIFO
//----------------------------------------
`include "merging_fifo_cfg.svh"
`default_nettype none

module merging_fifo_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import merging_fifo_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int IDLE_CYCLES   = 2;
  localparam int RANDOM_CYCLES = 400;
  localparam int MAX_REPS      = (1 << `MF_MATCH_WIDTH) - 1;
  localparam int FILL_PUSHES   = `MF_DEPTH * MAX_REPS;
  localparam int FULL_TRIES    = 4;
  localparam int EMPTY_TRIES   = 3;
  localparam int CLEAR_TRAFFIC = 40;
  localparam int CLEAR_PUSHES  = 8;
  localparam int DRAIN_CYCLES  = `MF_DEPTH * MAX_REPS;
  localparam int MARGIN        = 100;
  // Every step below costs one clock cycle, and the FIFO is drained three times
  localparam int MAX_CYCLES    = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + FILL_PUSHES +
                                 FULL_TRIES + EMPTY_TRIES + CLEAR_TRAFFIC + 2 +
                                 CLEAR_PUSHES + 3 * DRAIN_CYCLES + MARGIN;

  typedef struct packed {
    data_t value;
    int    reps;
  } entry_t;

  logic         clk;
  logic         rst_n;
  logic         clear;
  logic         push;
  logic         pop;
  data_t        data_in;
  data_t        data_out;
  fifo_status_t status;
  count_t       word_count;

  // One queue element per FIFO entry, and the words still owed at the output
  entry_t model_q[$];
  data_t  expect_q[$];
  data_t  alphabet[4] = '{8'h3c, 8'ha5, 8'h5a, 8'h0f};

  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  int checks;
  int accepted;
  int cycle_count;

  merging_fifo merging_fifo_inst (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_clear      (clear),
    .i_push       (push),
    .i_data       (data_in),
    .i_pop        (pop),
    .o_data       (data_out),
    .o_status     (status),
    .o_word_count (word_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic data_t pick_word();
    int idx;
    idx = $urandom_range(3, 0);
    return alphabet[idx];
  endfunction

  function automatic logic random_bit(int percent);
    return ($urandom_range(99, 0) < percent);
  endfunction

  // A word folds into the newest entry if it repeats that entry's value,
  // the count has room and the entry is not leaving in this cycle
  function automatic logic merge_allowed(data_t value, logic leaves);
    if (model_q.size() == 0) begin
      return 1'b0;
    end
    if (model_q[model_q.size() - 1].value != value) begin
      return 1'b0;
    end
    if (model_q[model_q.size() - 1].reps >= MAX_REPS) begin
      return 1'b0;
    end
    if (leaves && (model_q.size() == 1)) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_outputs(input logic match);
    count_t exp_count;
    logic   exp_empty;
    logic   exp_almost_full;
    logic   exp_full;
    exp_count       = count_t'(model_q.size());
    exp_empty       = (model_q.size() == 0);
    exp_almost_full = (model_q.size() >= `MF_THRESHOLD);
    exp_full        = (model_q.size() >= `MF_DEPTH) && !match;
    checks += 4;
    assert (word_count === exp_count) else begin
      $display("Fail o_word_count: got 0x%h, expected 0x%h", word_count, exp_count);
      test_errors++;
    end
    assert (status.empty === exp_empty) else begin
      $display("Fail o_status.empty: got 0x%h, expected 0x%h", status.empty, exp_empty);
      test_errors++;
    end
    assert (status.almost_full === exp_almost_full) else begin
      $display("Fail o_status.almost_full: got 0x%h, expected 0x%h",
               status.almost_full, exp_almost_full);
      test_errors++;
    end
    assert (status.full === exp_full) else begin
      $display("Fail o_status.full: got 0x%h, expected 0x%h", status.full, exp_full);
      test_errors++;
    end
    if (model_q.size() != 0) begin
      checks++;
      assert (data_out === model_q[0].value) else begin
        $display("Fail o_data: got 0x%h, expected 0x%h", data_out, model_q[0].value);
        test_errors++;
      end
    end
  endtask

  // The popped word must be the oldest accepted push not yet returned
  task automatic check_popped();
    data_t expected;
    checks++;
    assert (expect_q.size() != 0) else begin
      $display("A pop was accepted with no pushed word left to return");
      test_errors++;
    end
    if (expect_q.size() != 0) begin
      expected = expect_q.pop_front();
      assert (data_out === expected) else begin
        $display("Fail popped o_data: got 0x%h, expected 0x%h", data_out, expected);
        test_errors++;
      end
    end
  endtask

  // Each step is one clock cycle that drives at the rising edge, checks mid-cycle
  // and then advances the model
  task automatic step(input logic do_push, input data_t value, input logic do_pop,
                      input logic do_clear);
    logic   pop_ok;
    logic   leaves;
    logic   match;
    logic   push_new;
    entry_t e;
    @(posedge clk);
    push    <= do_push;
    data_in <= value;
    pop     <= do_pop;
    clear   <= do_clear;
    @(negedge clk);
    pop_ok   = do_pop && (model_q.size() != 0);
    leaves   = pop_ok && (model_q[0].reps == 1);
    match    = merge_allowed(value, leaves);
    push_new = do_push && (model_q.size() < `MF_DEPTH) && !match;
    check_outputs(match);
    // The DUT takes a push whenever its full flag is low
    if (do_push && !status.full) begin
      accepted++;
    end
    if (do_clear) begin
      model_q.delete();
      expect_q.delete();
    end else begin
      if (pop_ok) begin
        check_popped();
        if (leaves) begin
          model_q.delete(0);
        end else begin
          e = model_q[0];
          e.reps = e.reps - 1;
          model_q[0] = e;
        end
      end
      if (do_push && match) begin
        e = model_q[model_q.size() - 1];
        e.reps = e.reps + 1;
        model_q[model_q.size() - 1] = e;
        expect_q.push_back(value);
      end else if (push_new) begin
        e.value = value;
        e.reps  = 1;
        model_q.push_back(e);
        expect_q.push_back(value);
      end
    end
  endtask

  task automatic drain_fifo();
    int guard;
    guard = 0;
    while ((model_q.size() != 0) && (guard < DRAIN_CYCLES)) begin
      step(1'b0, pick_word(), 1'b1, 1'b0);
      guard++;
    end
    checks++;
    assert ((model_q.size() == 0) && (expect_q.size() == 0)) else begin
      $display("The FIFO still held words after %0d pops", guard);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  task automatic run_reset_test();
    repeat (IDLE_CYCLES) step(1'b0, pick_word(), 1'b0, 1'b0);
    finish_test("reset");
  endtask

  // Push-heavy first half reaches full, pop-heavy second half reaches empty
  task automatic run_random_test();
    int bias;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      bias = (i < RANDOM_CYCLES / 2) ? 65 : 35;
      step(random_bit(bias), pick_word(), random_bit(100 - bias), 1'b0);
    end
    drain_fifo();
    finish_test("random traffic");
  endtask

  task automatic run_fill_test();
    int    start;
    data_t value;
    start = accepted;
    value = alphabet[0];
    // Runs of MAX_REPS equal words where each run differs from the one before
    for (int i = 0; i < FILL_PUSHES; i++) begin
      value = alphabet[(i / MAX_REPS) % 4];
      step(1'b1, value, 1'b0, 1'b0);
    end
    checks++;
    assert (accepted - start == FILL_PUSHES) else begin
      $display("Only %0d of %0d merging pushes were accepted", accepted - start, FILL_PUSHES);
      test_errors++;
    end
    for (int i = 0; i < FULL_TRIES - 1; i++) begin
      step(1'b1, (value == alphabet[0]) ? alphabet[1] : alphabet[0], 1'b0, 1'b0);
    end
    // The newest entry is already at its highest count, so this one is refused too
    step(1'b1, value, 1'b0, 1'b0);
    checks++;
    assert (accepted - start == FILL_PUSHES) else begin
      $display("A push was accepted while the FIFO was full");
      test_errors++;
    end
    drain_fifo();
    repeat (EMPTY_TRIES) step(1'b0, pick_word(), 1'b1, 1'b0);
    finish_test("merge and full");
  endtask

  task automatic run_clear_test();
    for (int i = 0; i < CLEAR_TRAFFIC; i++) begin
      step(random_bit(60), pick_word(), random_bit(40), 1'b0);
    end
    step(random_bit(50), pick_word(), random_bit(50), 1'b1);
    step(1'b0, pick_word(), 1'b0, 1'b0);
    for (int i = 0; i < CLEAR_PUSHES; i++) begin
      step(1'b1, pick_word(), 1'b0, 1'b0);
    end
    drain_fifo();
    finish_test("clear");
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    clear        = 1'b0;
    push         = 1'b0;
    pop          = 1'b0;
    data_in      = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    accepted     = 0;
    void'($urandom(47));
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    run_reset_test();
    run_random_test();
    run_fill_test();
    run_clear_test();
    $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end
endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/merging_fifo_pkg.sv
hw/merging_fifo_controller.sv
hw/merging_fifo_storage.sv
hw/merging_fifo_head.sv
hw/merging_fifo.sv
verification/merging_fifo_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= merging_fifo_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
SEED      ?= 47
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR SEED VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
